// ==== project.f ====
rtl/imuldiv_pkg.sv
rtl/imuldiv_mul_dpath.sv
rtl/imuldiv_mul_ctrl.sv
rtl/imuldiv_div_dpath.sv
rtl/imuldiv_div_ctrl.sv
rtl/imuldiv_top.sv
verification/imuldiv_tb.sv

// ==== verification/imuldiv_tb.sv ====
// integer multiply/divide unit testbench
// directed corner tests, back-pressure and a random mix against a reference model
`timescale 1ns/100ps
`default_nettype none

module imuldiv_tb;

  import imuldiv_pkg::*;

  // ------------------------------------------------------------------------
  // run limits and timing
  // ------------------------------------------------------------------------

  // 16 mul corners, 16 div corners, 4 divide by zero, 8 stalled, 200 random
  localparam int num_ops     = 244;
  localparam int cycle_limit = 40 * num_ops + 200;
  // acceptance edge to the first edge that samples resp_val high
  localparam int resp_latency = 34;
  localparam int random_ops   = 200;

  logic          clk;
  logic          reset;
  imuldiv_req_t  req_msg;
  logic          req_val;
  logic          req_rdy;
  imuldiv_resp_u resp_msg;
  logic          resp_val;
  logic          resp_rdy;

  integer        seed = 82576;
  integer        cycle = 0;
  integer        accept_cycle = 0;
  integer        errors = 0;
  integer        checks = 0;

  imuldiv_top uut (
    .clk      (clk),
    .reset    (reset),
    .req_msg  (req_msg),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .resp_msg (resp_msg),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // watchdog
  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (cycle >= cycle_limit) begin
      $display("run stopped: no progress within %0d cycles", cycle_limit);
      $display("checks: %0d, errors: %0d", checks, errors + 1);
      $display("tests failed");
      $finish;
    end
  end

  // ------------------------------------------------------------------------
  // reference model and compare
  // ------------------------------------------------------------------------

  // remainder in the upper word for divides and quotients truncate toward zero
  function automatic logic [63:0] model(input imuldiv_fn_e fn, input logic [31:0] a,
                                        input logic [31:0] b);
    longint      sa;
    longint      sb;
    logic [63:0] res;
    sa = $signed(a);
    sb = $signed(b);
    case (fn)
      fn_mul: res = sa * sb;
      fn_mulu: res = {32'b0, a} * {32'b0, b};
      fn_div: begin
        // 64-bit math so min / -1 wraps back to min in the low word
        if (b == 32'b0) res = {a, 32'hffff_ffff};
        else res = {32'(sa % sb), 32'(sa / sb)};
      end
      default: begin
        if (b == 32'b0) res = {a, 32'hffff_ffff};
        else res = {a % b, a / b};
      end
    endcase
    return res;
  endfunction

  task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic compare_resp(input imuldiv_req_t r, input imuldiv_resp_u got);
    imuldiv_resp_u exp;
    exp.product = model(r.fn, r.a, r.b);
    if (r.fn[1]) begin
      check("resp_msg.divres.quot", got.divres.quot, exp.divres.quot);
      check("resp_msg.divres.rem", got.divres.rem, exp.divres.rem);
    end else begin
      check("resp_msg.product", got.product, exp.product);
    end
  endtask

  // ------------------------------------------------------------------------
  // driver and response tasks
  // ------------------------------------------------------------------------

  // outputs are sampled on the falling edge away from the driving edge
  task automatic send_req(input imuldiv_req_t r);
    @(posedge clk);
    req_msg <= r;
    req_val <= 1'b1;
    @(negedge clk);
    while (!req_rdy) @(negedge clk);
    // acceptance edge
    @(posedge clk);
    req_val <= 1'b0;
    @(negedge clk);
    accept_cycle = cycle;
  endtask

  task automatic get_resp(input int delay, output imuldiv_resp_u resp);
    imuldiv_resp_u held;
    int            seen_edge;
    @(negedge clk);
    while (!resp_val) @(negedge clk);
    // the next rising edge is the first to sample resp_val high
    seen_edge = cycle + 1;
    check("response latency", seen_edge - accept_cycle, resp_latency);
    held = resp_msg;
    // stalled response must hold and block new requests
    repeat (delay) begin
      @(negedge clk);
      check("resp_val", resp_val, 1'b1);
      check("resp_msg", resp_msg, held);
      check("req_rdy", req_rdy, 1'b0);
    end
    @(posedge clk);
    resp_rdy <= 1'b1;
    @(negedge clk);
    check("resp_val", resp_val, 1'b1);
    check("resp_msg", resp_msg, held);
    check("req_rdy", req_rdy, 1'b0);
    // transfer edge
    @(posedge clk);
    resp_rdy <= 1'b0;
    resp = held;
  endtask

  task automatic run_one(input imuldiv_fn_e fn, input logic [31:0] a, input logic [31:0] b,
                         input int delay);
    imuldiv_req_t  r;
    imuldiv_resp_u got;
    r.fn = fn;
    r.a  = a;
    r.b  = b;
    send_req(r);
    get_resp(delay, got);
    compare_resp(r, got);
  endtask

  // ------------------------------------------------------------------------
  // tests
  // ------------------------------------------------------------------------

  task automatic mul_corners();
    imuldiv_fn_e fn;
    for (int k = 0; k < 2; k++) begin
      if (k == 0) fn = fn_mul;
      else fn = fn_mulu;
      run_one(fn, 32'h0000_0000, 32'hffff_ffff, 0);
      run_one(fn, 32'h0000_0001, 32'h8000_0000, 0);
      run_one(fn, 32'hffff_ffff, 32'hffff_ffff, 0);
      run_one(fn, 32'h8000_0000, 32'h8000_0000, 0);
      run_one(fn, 32'h8000_0000, 32'hffff_ffff, 0);
      run_one(fn, 32'h7fff_ffff, 32'hffff_fffd, 0);
      run_one(fn, 32'hffff_fff9, 32'h0000_0006, 0);
      run_one(fn, 32'h1234_5678, 32'h9abc_def0, 0);
    end
  endtask

  task automatic div_corners();
    imuldiv_fn_e fn;
    for (int k = 0; k < 2; k++) begin
      if (k == 0) fn = fn_div;
      else fn = fn_divu;
      run_one(fn, 32'h0000_0007, 32'h0000_0002, 0);
      // negative dividend, positive divisor
      run_one(fn, 32'hffff_fff9, 32'h0000_0002, 0);
      // both negative
      run_one(fn, 32'hffff_fff9, 32'hffff_fffe, 0);
      run_one(fn, 32'h0000_0007, 32'hffff_fffe, 0);
      // most negative over minus one
      run_one(fn, 32'h8000_0000, 32'hffff_ffff, 0);
      run_one(fn, 32'h8000_0000, 32'h0000_0001, 0);
      run_one(fn, 32'hffff_ffff, 32'h0000_0001, 0);
      run_one(fn, 32'h0000_0000, 32'h0000_0005, 0);
    end
  endtask

  task automatic div_by_zero();
    run_one(fn_div, 32'h1234_5678, 32'h0000_0000, 0);
    run_one(fn_div, 32'hffff_fff9, 32'h0000_0000, 0);
    run_one(fn_divu, 32'h1234_5678, 32'h0000_0000, 0);
    run_one(fn_divu, 32'hffff_fff9, 32'h0000_0000, 0);
  endtask

  task automatic stalled_responses();
    logic [31:0] rnd;
    logic [31:0] a;
    logic [31:0] b;
    for (int i = 0; i < 8; i++) begin
      rnd = $random(seed);
      a   = $random(seed);
      b   = $random(seed);
      run_one(imuldiv_fn_e'(rnd[1:0]), a, b, rnd % 11);
    end
  endtask

  // producer and consumer run side by side and a queue keeps request order
  task automatic random_mix();
    imuldiv_req_t  sent_q[$];
    imuldiv_req_t  r;
    imuldiv_req_t  exp_r;
    imuldiv_resp_u got;
    logic [31:0]   rnd;
    fork
      begin
        for (int i = 0; i < random_ops; i++) begin
          rnd  = $random(seed);
          r.fn = imuldiv_fn_e'(rnd[1:0]);
          r.a  = $random(seed);
          r.b  = $random(seed);
          sent_q.push_back(r);
          send_req(r);
        end
      end
      begin
        for (int j = 0; j < random_ops; j++) begin
          get_resp(0, got);
          exp_r = sent_q.pop_front();
          compare_resp(exp_r, got);
        end
      end
    join
  endtask

  // ------------------------------------------------------------------------
  // main sequence
  // ------------------------------------------------------------------------

  initial begin
    reset    = 1'b1;
    req_msg  = '0;
    req_val  = 1'b0;
    resp_rdy = 1'b0;
    repeat (16) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    check("req_rdy", req_rdy, 1'b1);
    check("resp_val", resp_val, 1'b0);

    mul_corners();
    div_corners();
    div_by_zero();
    stalled_responses();
    random_mix();

    @(negedge clk);
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== rtl/imuldiv_top.sv ====
// integer multiply/divide unit top level
// steers each request to one unit and returns that unit's response
`timescale 1ns/100ps
`default_nettype none

module imuldiv_top (
  input  logic                       clk,
  input  logic                       reset,
  input  imuldiv_pkg::imuldiv_req_t  req_msg,
  input  logic                       req_val,
  output logic                       req_rdy,
  output imuldiv_pkg::imuldiv_resp_u resp_msg,
  output logic                       resp_val,
  input  logic                       resp_rdy
);

  import imuldiv_pkg::*;

  // one-hot owner with bit 0 for the multiplier and bit 1 for the divider
  logic [1:0] owner;
  logic       is_div;
  logic       idle;
  logic       req_go;
  logic       resp_go;

  logic              mul_req_val;
  logic              mul_req_rdy;
  logic              mul_resp_val;
  logic              mul_resp_rdy;
  logic              mul_a_en;
  logic              mul_a_sel;
  logic              mul_b_en;
  logic              mul_b_sel;
  logic              mul_acc_en;
  logic              mul_fix_en;
  logic [2*xlen-1:0] mul_product;
  imuldiv_resp_u     mul_resp;

  logic              div_req_val;
  logic              div_req_rdy;
  logic              div_resp_val;
  logic              div_resp_rdy;
  logic              div_load_en;
  logic              div_step_en;
  logic              div_fix_en;
  imuldiv_resp_u     div_result;

  // ------------------------------------------------------------------------
  // request steering
  // ------------------------------------------------------------------------

  assign is_div  = req_msg.fn[1];
  assign idle    = (owner == 2'b00);
  assign req_rdy = idle && mul_req_rdy && div_req_rdy;
  assign req_go  = req_val && req_rdy;

  assign mul_req_val = req_val && idle && !is_div;
  assign div_req_val = req_val && idle && is_div;

  always_ff @(posedge clk) begin
    if (reset) begin
      owner <= 2'b00;
    end else if (req_go) begin
      owner <= is_div ? 2'b10 : 2'b01;
    end else if (resp_go) begin
      owner <= 2'b00;
    end
  end

  // ------------------------------------------------------------------------
  // units
  // ------------------------------------------------------------------------

  imuldiv_mul_ctrl mul_ctrl (
    .clk      (clk),
    .reset    (reset),
    .req_val  (mul_req_val),
    .req_rdy  (mul_req_rdy),
    .resp_val (mul_resp_val),
    .resp_rdy (mul_resp_rdy),
    .a_en     (mul_a_en),
    .a_sel    (mul_a_sel),
    .b_en     (mul_b_en),
    .b_sel    (mul_b_sel),
    .acc_en   (mul_acc_en),
    .fix_en   (mul_fix_en)
  );

  imuldiv_mul_dpath mul_dpath (
    .clk     (clk),
    .reset   (reset),
    .req_msg (req_msg),
    .a_en    (mul_a_en),
    .a_sel   (mul_a_sel),
    .b_en    (mul_b_en),
    .b_sel   (mul_b_sel),
    .acc_en  (mul_acc_en),
    .fix_en  (mul_fix_en),
    .product (mul_product)
  );

  imuldiv_div_ctrl div_ctrl (
    .clk      (clk),
    .reset    (reset),
    .req_val  (div_req_val),
    .req_rdy  (div_req_rdy),
    .resp_val (div_resp_val),
    .resp_rdy (div_resp_rdy),
    .load_en  (div_load_en),
    .step_en  (div_step_en),
    .fix_en   (div_fix_en)
  );

  imuldiv_div_dpath div_dpath (
    .clk     (clk),
    .reset   (reset),
    .req_msg (req_msg),
    .load_en (div_load_en),
    .step_en (div_step_en),
    .fix_en  (div_fix_en),
    .result  (div_result)
  );

  // ------------------------------------------------------------------------
  // response mux
  // ------------------------------------------------------------------------

  always_comb begin
    mul_resp.product = mul_product;
  end

  assign resp_val = (owner[0] && mul_resp_val) || (owner[1] && div_resp_val);
  assign resp_msg = owner[1] ? div_result : mul_resp;
  assign resp_go  = resp_val && resp_rdy;

  // ready goes back only to the unit that owns the operation
  assign mul_resp_rdy = resp_rdy && owner[0];
  assign div_resp_rdy = resp_rdy && owner[1];

  assert property (@(posedge clk) disable iff (reset)
    !(mul_resp_val && div_resp_val));

  // a stalled response keeps its value until taken
  assert property (@(posedge clk) disable iff (reset)
    (resp_val && !resp_rdy) |=> (resp_val && $stable(resp_msg)));

endmodule

`default_nettype wire

// ==== rtl/imuldiv_div_ctrl.sv ====
// iterative divider control
// state machine and iteration counter driving load, step and fix enables
`timescale 1ns/100ps
`default_nettype none

module imuldiv_div_ctrl (
  input  logic clk,
  input  logic reset,
  input  logic req_val,
  output logic req_rdy,
  output logic resp_val,
  input  logic resp_rdy,
  output logic load_en,
  output logic step_en,
  output logic fix_en
);

  import imuldiv_pkg::*;

  ctrl_state_e            state;
  logic [count_width-1:0] count;
  logic                   req_go;
  logic                   resp_go;
  logic                   last_iter;

  assign req_go    = req_val && req_rdy;
  assign resp_go   = resp_val && resp_rdy;
  assign last_iter = (count == count_width'(iter_count - 1));

  // ------------------------------------------------------------------------
  // state and counter
  // ------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
      count <= '0;
    end else begin
      case (state)
        st_idle: begin
          if (req_go) begin
            state <= st_calc;
            count <= '0;
          end
        end
        st_calc: begin
          if (last_iter) begin
            state <= st_fix;
          end else begin
            count <= count + 1'b1;
          end
        end
        st_fix: begin
          state <= st_done;
        end
        st_done: begin
          // back-pressure keeps us here with the result held
          if (resp_go) begin
            state <= st_idle;
          end
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

  // ------------------------------------------------------------------------
  // outputs
  // ------------------------------------------------------------------------

  always_comb begin
    req_rdy  = 1'b0;
    resp_val = 1'b0;
    load_en  = 1'b0;
    step_en  = 1'b0;
    fix_en   = 1'b0;
    case (state)
      st_idle: begin
        req_rdy = 1'b1;
        load_en = req_go;
      end
      st_calc: begin
        step_en = 1'b1;
      end
      st_fix: begin
        fix_en = 1'b1;
      end
      default: begin
        resp_val = 1'b1;
      end
    endcase
  end

  // only an idle divider takes a new request
  assert property (@(posedge clk) disable iff (reset)
    req_rdy |-> (state == st_idle));

endmodule

`default_nettype wire

// ==== rtl/imuldiv_div_dpath.sv ====
// iterative restoring divider datapath
// shift-and-subtract on magnitudes, then sign and divide-by-zero correction
`timescale 1ns/100ps
`default_nettype none

module imuldiv_div_dpath (
  input  logic                       clk,
  input  logic                       reset,
  input  imuldiv_pkg::imuldiv_req_t  req_msg,
  input  logic                       load_en,
  input  logic                       step_en,
  input  logic                       fix_en,
  output imuldiv_pkg::imuldiv_resp_u result
);

  import imuldiv_pkg::*;

  // remainder in upper half, dividend bits and then quotient in lower half
  logic [2*xlen-1:0] rq_reg;
  logic [xlen-1:0]   dsr_reg;
  // original dividend, returned as remainder on divide by zero
  logic [xlen-1:0]   dvd_reg;
  logic              neg_quot_reg;
  logic              neg_rem_reg;
  logic              zero_reg;

  logic              is_signed;
  logic              a_neg;
  logic              b_neg;
  logic              b_zero;
  logic [xlen-1:0]   a_mag;
  logic [xlen-1:0]   b_mag;
  logic [xlen:0]     partial;
  logic [xlen:0]     diff;
  logic              fits;
  logic [2*xlen-1:0] step_next;
  logic [xlen-1:0]   rem_cur;
  logic [xlen-1:0]   quot_cur;
  logic [xlen-1:0]   rem_fix;
  logic [xlen-1:0]   quot_fix;

  // ------------------------------------------------------------------------
  // operand magnitudes and result signs
  // ------------------------------------------------------------------------

  assign is_signed = (req_msg.fn == fn_div);
  assign a_neg     = is_signed && req_msg.a[xlen-1];
  assign b_neg     = is_signed && req_msg.b[xlen-1];
  assign b_zero    = (req_msg.b == '0);
  assign a_mag     = a_neg ? -req_msg.a : req_msg.a;
  assign b_mag     = b_neg ? -req_msg.b : req_msg.b;

  // ------------------------------------------------------------------------
  // one restoring step
  // ------------------------------------------------------------------------

  // shifted remainder needs 33 bits before the compare
  assign partial = rq_reg[2*xlen-1:xlen-1];
  assign diff    = partial - {1'b0, dsr_reg};
  assign fits    = !diff[xlen];

  // keep the difference and shift in a one, else just shift
  assign step_next = fits ? {diff[xlen-1:0], rq_reg[xlen-2:0], 1'b1}
                          : {rq_reg[2*xlen-2:0], 1'b0};

  // ------------------------------------------------------------------------
  // correction
  // ------------------------------------------------------------------------

  assign rem_cur  = rq_reg[2*xlen-1:xlen];
  assign quot_cur = rq_reg[xlen-1:0];

  // zero divisor leaves the all-ones quotient alone
  assign quot_fix = neg_quot_reg ? -quot_cur : quot_cur;
  assign rem_fix  = zero_reg    ? dvd_reg   :
                    neg_rem_reg ? -rem_cur  : rem_cur;

  always_ff @(posedge clk) begin
    if (load_en) begin
      rq_reg       <= {{xlen{1'b0}}, a_mag};
      dsr_reg      <= b_mag;
      dvd_reg      <= req_msg.a;
      zero_reg     <= b_zero;
      // quotient negative when signs differ
      neg_quot_reg <= (a_neg ^ b_neg) && !b_zero;
      // remainder follows the dividend
      neg_rem_reg  <= a_neg;
    end else if (step_en) begin
      rq_reg <= step_next;
    end else if (fix_en) begin
      rq_reg <= {rem_fix, quot_fix};
    end
  end

  always_comb begin
    result.divres = imuldiv_divres_t'(rq_reg);
  end

  // correction comes right after the last shift step
  assert property (@(posedge clk) disable iff (reset)
    fix_en |-> ($past(step_en) && !load_en && !step_en));

endmodule

`default_nettype wire

// ==== rtl/imuldiv_mul_ctrl.sv ====
// iterative multiplier control
// state machine and iteration counter driving datapath enables and handshakes
`timescale 1ns/100ps
`default_nettype none

module imuldiv_mul_ctrl (
  input  logic clk,
  input  logic reset,
  input  logic req_val,
  output logic req_rdy,
  output logic resp_val,
  input  logic resp_rdy,
  output logic a_en,
  output logic a_sel,
  output logic b_en,
  output logic b_sel,
  output logic acc_en,
  output logic fix_en
);

  import imuldiv_pkg::*;

  ctrl_state_e            state;
  logic [count_width-1:0] count;
  logic                   req_go;
  logic                   resp_go;
  logic                   last_iter;

  assign req_go    = req_val && req_rdy;
  assign resp_go   = resp_val && resp_rdy;
  assign last_iter = (count == count_width'(iter_count - 1));

  // ------------------------------------------------------------------------
  // state and counter
  // ------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
      count <= '0;
    end else begin
      case (state)
        st_idle: begin
          if (req_go) begin
            state <= st_calc;
            count <= '0;
          end
        end
        st_calc: begin
          // 32 shift steps, then sign fix
          if (last_iter) begin
            state <= st_fix;
          end else begin
            count <= count + 1'b1;
          end
        end
        st_fix: begin
          state <= st_done;
        end
        st_done: begin
          // hold result until the consumer takes it
          if (resp_go) begin
            state <= st_idle;
          end
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

  // ------------------------------------------------------------------------
  // outputs
  // ------------------------------------------------------------------------

  always_comb begin
    req_rdy  = 1'b0;
    resp_val = 1'b0;
    a_en     = 1'b0;
    a_sel    = 1'b0;
    b_en     = 1'b0;
    b_sel    = 1'b0;
    acc_en   = 1'b0;
    fix_en   = 1'b0;
    case (state)
      st_idle: begin
        req_rdy = 1'b1;
        // load magnitudes and clear accumulator on acceptance
        a_en    = req_go;
        b_en    = req_go;
        acc_en  = req_go;
      end
      st_calc: begin
        a_en   = 1'b1;
        a_sel  = 1'b1;
        b_en   = 1'b1;
        b_sel  = 1'b1;
        acc_en = 1'b1;
      end
      st_fix: begin
        fix_en = 1'b1;
      end
      default: begin
        resp_val = 1'b1;
      end
    endcase
  end

  assert property (@(posedge clk) disable iff (reset)
    (state == st_calc) |-> (count <= count_width'(iter_count - 1)));

  assert property (@(posedge clk) disable iff (reset)
    resp_val |-> (state == st_done));

endmodule

`default_nettype wire

// ==== rtl/imuldiv_mul_dpath.sv ====
// iterative multiplier datapath
// shift-and-add on operand magnitudes, then one sign correction step
`timescale 1ns/100ps
`default_nettype none

module imuldiv_mul_dpath (
  input  logic                            clk,
  input  logic                            reset,
  input  imuldiv_pkg::imuldiv_req_t       req_msg,
  input  logic                            a_en,
  input  logic                            a_sel,
  input  logic                            b_en,
  input  logic                            b_sel,
  input  logic                            acc_en,
  input  logic                            fix_en,
  output logic [2*imuldiv_pkg::xlen-1:0]  product
);

  import imuldiv_pkg::*;

  // multiplicand grows left, multiplier drains right
  logic [2*xlen-1:0] a_reg;
  logic [xlen-1:0]   b_reg;
  logic [2*xlen-1:0] acc_reg;
  // result sign, captured at load
  logic              neg_reg;

  logic              is_signed;
  logic [xlen-1:0]   a_mag;
  logic [xlen-1:0]   b_mag;
  logic              neg_in;
  logic [2*xlen-1:0] a_next;
  logic [xlen-1:0]   b_next;
  logic [2*xlen-1:0] partial;
  logic [2*xlen-1:0] acc_sum;

  // ------------------------------------------------------------------------
  // operand magnitudes
  // ------------------------------------------------------------------------

  // only mul treats its operands as two's complement
  assign is_signed = (req_msg.fn == fn_mul);
  assign a_mag     = (is_signed && req_msg.a[xlen-1]) ? -req_msg.a : req_msg.a;
  assign b_mag     = (is_signed && req_msg.b[xlen-1]) ? -req_msg.b : req_msg.b;
  assign neg_in    = is_signed && (req_msg.a[xlen-1] ^ req_msg.b[xlen-1]);

  // ------------------------------------------------------------------------
  // shift and add
  // ------------------------------------------------------------------------

  // select 0 loads, select 1 shifts
  assign a_next = a_sel ? (a_reg << 1) : {{xlen{1'b0}}, a_mag};
  assign b_next = b_sel ? (b_reg >> 1) : b_mag;

  // add shifted multiplicand when the current multiplier bit is set
  assign partial = b_reg[0] ? a_reg : '0;
  assign acc_sum = acc_reg + partial;

  always_ff @(posedge clk) begin
    if (a_en) begin
      a_reg <= a_next;
    end
    if (b_en) begin
      b_reg <= b_next;
    end
    // sign only changes on the load cycle
    if (a_en && !a_sel) begin
      neg_reg <= neg_in;
    end
  end

  // accumulator follows the a select and clears on load
  always_ff @(posedge clk) begin
    if (acc_en) begin
      acc_reg <= a_sel ? acc_sum : '0;
    end else if (fix_en && neg_reg) begin
      acc_reg <= -acc_reg;
    end
  end

  assign product = acc_reg;

  // sign fix runs alone, never together with a load or a shift step
  assert property (@(posedge clk) disable iff (reset)
    fix_en |-> !(a_en || acc_en));

endmodule

`default_nettype wire

// ==== rtl/imuldiv_pkg.sv ====
// integer multiply/divide unit shared definitions
// operation codes, widths, request and response formats
`default_nettype none

package imuldiv_pkg;

  // ------------------------------------------------------------------------
  // widths and iteration count
  // ------------------------------------------------------------------------

  // operand width, fixed by the instruction set
  localparam int xlen = 32;

  // one shift step per operand bit
  localparam int iter_count = 32;

  // counter holds 0 .. iter_count-1 with room to spare
  localparam int count_width = 6;

  // ------------------------------------------------------------------------
  // request
  // ------------------------------------------------------------------------

  // bit 1 picks the divider, bit 0 picks unsigned
  typedef enum logic [1:0] {
    fn_mul  = 2'b00,
    fn_mulu = 2'b01,
    fn_div  = 2'b10,
    fn_divu = 2'b11
  } imuldiv_fn_e;

  // a is multiplicand or dividend, b is multiplier or divisor
  typedef struct packed {
    imuldiv_fn_e     fn;
    logic [xlen-1:0] a;
    logic [xlen-1:0] b;
  } imuldiv_req_t;

  // ------------------------------------------------------------------------
  // response
  // ------------------------------------------------------------------------

  // remainder sits in the upper half
  typedef struct packed {
    logic [xlen-1:0] rem;
    logic [xlen-1:0] quot;
  } imuldiv_divres_t;

  // same word carries either a full product or a quotient/remainder pair
  typedef union packed {
    logic [2*xlen-1:0] product;
    imuldiv_divres_t   divres;
  } imuldiv_resp_u;

  // controller sequence shared by both units
  typedef enum logic [1:0] {
    st_idle = 2'd0,
    st_calc = 2'd1,
    st_fix  = 2'd2,
    st_done = 2'd3
  } ctrl_state_e;

endpackage

`default_nettype wire
